// ==== Makefile ====
# Verilator build and run for the cps2Decrypt testbench
# override any variable on the command line, e.g. make run OBJDIR=build

VERILATOR ?= verilator
TOP       ?= cps2Decrypt_tb
FILELIST  ?= cps2Decrypt.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUNARGS   ?= +verilator+error+limit+100
PASS_MSG  ?= === PASS ===

SIM := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: compile
	@out="$$($(SIM) $(RUNARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== cps2Decrypt.f ====
+incdir+.
cps2DecryptPkg.sv
cps2KeyLoad.sv
cps2KeySchedule.sv
cps2FeistelRound.sv
cps2DecryptCtrl.sv
cps2Decrypt.sv
cps2Decrypt_chk.sv
cps2Decrypt_tb.sv

// ==== cps2Decrypt.sv ====
/*
  CPS2 opcode decryptor
  Key loader, key schedule, Feistel datapath and sequencer.
  Opcode words inside the keyed range are decrypted, everything
  else passes through with the same five-cycle latency.
*/
`timescale 1ns/1ps

module cps2Decrypt (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             keyByte,
    input  logic                   keyWe,
    input  logic                   fetchReq,
    input  cps2DecryptPkg::fetch_t fetch,
    output logic                   busy,
    output logic                   plainValid,
    output logic [15:0]            plainData
);

    import cps2DecryptPkg::*;

    keyCfg_t    keyCfg;     // loader to schedule
    roundKey_t  roundKey;   // schedule to datapath
    logic       load;       // also the schedule's capture
    logic       step;
    logic [1:0] roundIdx;

    cps2KeyLoad keyLoad0 (
        .clk     (clk),
        .rst     (rst),
        .keyByte (keyByte),
        .keyWe   (keyWe),
        .keyCfg  (keyCfg)
    );

    cps2KeySchedule keySched0 (
        .clk      (clk),
        .rst      (rst),
        .capture  (load),
        .fetch    (fetch),
        .keyCfg   (keyCfg),
        .roundKey (roundKey)
    );

    cps2FeistelRound feistel0 (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .step      (step),
        .roundIdx  (roundIdx),
        .data      (fetch.data),
        .roundKey  (roundKey),
        .plainData (plainData)
    );

    cps2DecryptCtrl ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .fetchReq   (fetchReq),
        .load       (load),
        .step       (step),
        .roundIdx   (roundIdx),
        .busy       (busy),
        .plainValid (plainValid)
    );

endmodule

// ==== cps2DecryptCtrl.sv ====
/*
  CPS2 decryption sequencer
  Accepts a fetch request only when idle, steps the datapath
  through the rounds and pulses the result strobe for one cycle.
*/
`timescale 1ns/1ps

module cps2DecryptCtrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       fetchReq,
    output logic       load,
    output logic       step,
    output logic [1:0] roundIdx,
    output logic       busy,
    output logic       plainValid
);

    `include "cps2Decrypt_macros.svh"

    localparam logic [1:0] LAST_ROUND = 2'(`CPS2_ROUNDS - 1);

    logic       active;     // rounds in progress
    logic [1:0] rnd;        // round applied at the next edge
    logic       validQ;     // result strobe

    // request while busy is dropped
    assign load = fetchReq && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            rnd    <= 2'd0;
            validQ <= 1'b0;
        end else begin
            validQ <= 1'b0;                 // one cycle only
            if (load) begin
                active <= 1'b1;             // edge 0, datapath loads
                rnd    <= 2'd0;
            end else if (active) begin
                rnd <= rnd + 2'd1;
                if (rnd == LAST_ROUND) begin
                    active <= 1'b0;         // last round at edge 4
                    validQ <= 1'b1;
                end
            end
        end
    end

    assign step       = active;
    assign roundIdx   = rnd;
    assign plainValid = validQ;
    assign busy       = active || validQ;   // held until the strobe drops

endmodule

// ==== cps2DecryptPkg.sv ====
/*
  CPS2 decryption types
  Packed structs shared by the key loader, the key schedule,
  the Feistel datapath and the top level.
*/
`include "cps2Decrypt_macros.svh"

package cps2DecryptPkg;

    // loader output, combinational from the blob register
    typedef struct packed {
        logic [15:0] addrLimit;        // highest encrypted address, bits 22..7
        logic [63:0] masterKey;        // Feistel master key
    } keyCfg_t;

    // one bus fetch from the CPU side
    typedef struct packed {
        logic [`CPS2_ADDR_W-1:0] addr; // word address
        logic [15:0]             data; // word as read from ROM
        logic                    isOpcode; // instruction fetch, not data read
    } fetch_t;

    // per-fetch key material handed to the datapath
    typedef struct packed {
        logic                              encrypted; // word lies in range
        logic [15:0]                       whiten;    // pre-round whitening
        logic [`CPS2_ROUNDS-1:0][7:0]      subKey;    // one byte per round
    } roundKey_t;

endpackage

// ==== cps2Decrypt_chk.sv ====
/*
  cps2Decrypt protocol checker
  Bound into the top level. Watches the result strobe width,
  the five-cycle latency, busy after reset and key writes
  during a fetch.
*/
`timescale 1ns/1ps

module cps2Decrypt_chk (
    input logic clk,
    input logic rst,
    input logic keyWe,
    input logic fetchReq,
    input logic busy,
    input logic plainValid
);

    int assertFails = 0;    // failure tally, read at end of run

    validPulse: assert property (@(posedge clk) disable iff (rst)
        plainValid |=> !plainValid)
        else begin
            assertFails++;
            $error("plainValid high for more than one cycle");
        end

    // accepted at edge 0, strobe seen at edge 5
    validLatency: assert property (@(posedge clk) disable iff (rst)
        (fetchReq && !busy) |-> ##5 plainValid)
        else begin
            assertFails++;
            $error("plainValid not 5 cycles after an accepted fetchReq");
        end

    resetQuiet: assert property (@(posedge clk)
        rst |-> (!busy && !plainValid))
        else begin
            assertFails++;
            $error("busy or plainValid high during reset");
        end

    keyIdle: assert property (@(posedge clk) disable iff (rst)
        $rose(keyWe) |-> !busy)
        else begin
            assertFails++;
            $error("key byte written while a fetch is in flight");
        end

endmodule

bind cps2Decrypt cps2Decrypt_chk chk0 (
    .clk        (clk),
    .rst        (rst),
    .keyWe      (keyWe),
    .fetchReq   (fetchReq),
    .busy       (busy),
    .plainValid (plainValid)
);

// ==== cps2Decrypt_macros.svh ====
/*
  CPS2 opcode decryption constants
  Key blob length, Feistel round count and 68000 word-address width.
*/
`ifndef CPS2_DECRYPT_MACROS_SVH
`define CPS2_DECRYPT_MACROS_SVH

// bytes in the configuration blob, one per write strobe
`define CPS2_BLOB_BYTES 20

// Feistel rounds applied to an encrypted opcode word
`define CPS2_ROUNDS 4

// 68000 word address, A23..A1
`define CPS2_ADDR_W 23

`endif

// ==== cps2Decrypt_tb.sv ====
/*
  cps2Decrypt testbench
  Directed tests against a reference model of the key scatter,
  the range test and the Feistel rounds. Blobs, addresses and
  data words come from a fixed random seed.
*/
`timescale 1ns/1ps

module cps2Decrypt_tb;

    import cps2DecryptPkg::*;
    `include "cps2Decrypt_macros.svh"

    localparam int PERIOD      = 40;
    localparam int BLOB_W      = 8 * `CPS2_BLOB_BYTES;
    localparam int TEST_CYCLES = 3 * 2 * `CPS2_BLOB_BYTES + 16 * 8 + 40; // blobs, fetches, resets
    localparam int MARGIN      = 100;

    logic              clk = 1'b0;
    logic              rst;
    logic [7:0]        keyByte;
    logic              keyWe;
    logic              fetchReq;
    fetch_t            fetch;
    logic              busy;
    logic              plainValid;
    logic [15:0]       plainData;
    logic [BLOB_W-1:0] modelRaw;    // expected content of the blob register
    int                errors = 0;
    integer            seed = 32'hc0608afa;

    always #(PERIOD / 2) clk = ~clk;

    cps2Decrypt dut0 (
        .clk        (clk),
        .rst        (rst),
        .keyByte    (keyByte),
        .keyWe      (keyWe),
        .fetchReq   (fetchReq),
        .fetch      (fetch),
        .busy       (busy),
        .plainValid (plainValid),
        .plainData  (plainData)
    );

    // scrambled byte b is raw byte (7b+13) mod 20 rotated right by b
    function automatic logic [7:0] scrambleByte(input logic [BLOB_W-1:0] raw, input int b);
        logic [7:0]  src;
        logic [15:0] dbl;
        src = raw[8 * ((7 * b + 13) % `CPS2_BLOB_BYTES) +: 8];
        dbl = {src, src} >> (b % 8);
        return dbl[7:0];
    endfunction

    function automatic logic [63:0] keyFromBlob(input logic [BLOB_W-1:0] raw);
        logic [63:0] key;
        for (int b = 0; b < 8; b++) begin
            key[8 * b +: 8] = scrambleByte(raw, b);
        end
        return key;
    endfunction

    function automatic logic [15:0] limitFromBlob(input logic [BLOB_W-1:0] raw);
        return {scrambleByte(raw, 19), scrambleByte(raw, 18)}; // map bits 159..144
    endfunction

    // expected word for one fetch under the given blob
    function automatic logic [15:0] expectedWord(input logic [BLOB_W-1:0] raw, input fetch_t f);
        logic [63:0] key;
        logic [7:0]  l;
        logic [7:0]  r;
        logic [7:0]  t;
        logic [15:0] dbl;
        key = keyFromBlob(raw);
        if (!f.isOpcode || f.addr[`CPS2_ADDR_W-1 -: 16] > limitFromBlob(raw)) begin
            return f.data;              // bypass
        end
        l = f.data[15:8] ^ key[63:56];  // whitening
        r = f.data[7:0] ^ key[55:48];
        for (int i = 0; i < `CPS2_ROUNDS; i++) begin
            t   = r ^ key[8 * i +: 8] ^ f.addr[8 * (i % 2) +: 8];
            dbl = {t, t} >> (7 - i);    // rotate left by i+1
            t   = l ^ dbl[7:0];
            l   = r;
            r   = t;
        end
        return {l, r};
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    // one configuration byte with the strobe high for hold cycles
    task automatic writeByte(input logic [7:0] b, input int hold);
        keyByte = b;
        keyWe   = 1'b1;
        repeat (hold) tick();
        keyWe = 1'b0;
        tick();
        modelRaw = {b, modelRaw[BLOB_W-1:8]}; // one byte whatever the hold
    endtask

    task automatic loadBlob();
        logic [31:0] r;
        for (int i = 0; i < `CPS2_BLOB_BYTES; i++) begin
            r = $random(seed);
            writeByte(r[7:0], 1);
        end
    endtask

    // random fetch below or above the current limit
    task automatic makeFetch(input logic isOp, input logic above, output fetch_t f);
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] lim;
        logic [15:0] hi;
        r   = $random(seed);
        d   = $random(seed);
        lim = {16'h0, limitFromBlob(modelRaw)};
        if (above) begin
            hi = 16'(lim + 32'd1 + ({16'h0, r[31:16]} % (32'hffff - lim)));
        end else begin
            hi = 16'({16'h0, r[31:16]} % (lim + 32'd1));
        end
        f.addr     = {hi, r[6:0]};
        f.data     = d[15:0];
        f.isOpcode = isOp;
    endtask

    // one request then a bounded wait for the strobe
    task automatic runFetch(input fetch_t f, output logic [15:0] word, output int lat);
        fetch    = f;
        fetchReq = 1'b1;
        tick();                         // edge 0
        fetchReq = 1'b0;
        lat = 1;
        compare("busy", 32'(busy), 32'd1);
        while (!plainValid && lat < 20) begin
            tick();
            lat++;
            compare("busy", 32'(busy), 32'd1); // held through the strobe cycle
        end
        if (!plainValid) begin
            errors++;
            $display("no plainValid within 20 cycles of the request");
        end
        word = plainData;
        tick();
        compare("plainValid", 32'(plainValid), 32'd0); // strobe gone again
        compare("busy", 32'(busy), 32'd0);
    endtask

    task automatic checkFetch(input fetch_t f);
        logic [15:0] word;
        int          lat;
        runFetch(f, word, lat);
        compare("plainData", 32'(word), 32'(expectedWord(modelRaw, f)));
        compare("latency", lat, 32'd5);
    endtask

    task automatic inRangeTest();
        fetch_t f;
        loadBlob();
        repeat (4) begin
            makeFetch(1'b1, 1'b0, f);
            checkFetch(f);
        end
    endtask

    task automatic bypassTest();
        fetch_t      f;
        logic [15:0] word;
        int          lat;
        for (int i = 0; i < 3; i++) begin
            if (limitFromBlob(modelRaw) != 16'hffff) begin // nothing lies above a full limit
                makeFetch(1'b1, 1'b1, f);
                runFetch(f, word, lat);
                compare("plainData", 32'(word), 32'(f.data));
                compare("latency", lat, 32'd5);
            end
            makeFetch(1'b0, 1'b0, f);   // data read in range
            runFetch(f, word, lat);
            compare("plainData", 32'(word), 32'(f.data));
            compare("latency", lat, 32'd5);
        end
    endtask

    task automatic heldStrobeTest();
        fetch_t      f;
        logic [31:0] r;
        r = $random(seed);
        writeByte(r[7:0], 5);           // one byte from five high cycles
        repeat (2) begin
            makeFetch(1'b1, 1'b0, f);
            checkFetch(f);
        end
    endtask

    task automatic busyDropTest();
        fetch_t      f1;
        fetch_t      f2;
        int          seen;
        logic [15:0] word;
        makeFetch(1'b1, 1'b0, f1);
        makeFetch(1'b1, 1'b0, f2);
        seen     = 0;
        word     = 16'h0;
        fetch    = f1;
        fetchReq = 1'b1;
        tick();                         // accepted here
        fetchReq = 1'b0;
        compare("busy", 32'(busy), 32'd1);
        tick();
        fetch    = f2;                  // lands mid-rounds
        fetchReq = 1'b1;
        tick();
        fetchReq = 1'b0;
        repeat (10) begin
            if (plainValid) begin
                seen++;
                word = plainData;
            end
            tick();
        end
        compare("plainValid count", 32'(seen), 32'd1);
        compare("plainData", 32'(word), 32'(expectedWord(modelRaw, f1)));
    endtask

    task automatic reloadTest();
        fetch_t f;
        loadBlob();                     // full blob replaces the old key
        repeat (2) begin
            makeFetch(1'b1, 1'b0, f);
            checkFetch(f);
        end
    endtask

    task automatic resetMidTest();
        fetch_t f;
        makeFetch(1'b1, 1'b0, f);
        fetch    = f;
        fetchReq = 1'b1;
        tick();
        fetchReq = 1'b0;
        tick();
        rst      = 1'b1;                // one round in
        modelRaw = '0;
        repeat (4) begin
            tick();
            compare("busy", 32'(busy), 32'd0);
            compare("plainValid", 32'(plainValid), 32'd0);
        end
        rst = 1'b0;
        repeat (6) begin
            tick();
            compare("busy", 32'(busy), 32'd0);
            compare("plainValid", 32'(plainValid), 32'd0);
        end
        makeFetch(1'b1, 1'b0, f);       // zero limit so address bits 22..7 are zero
        checkFetch(f);
        makeFetch(1'b0, 1'b0, f);
        checkFetch(f);
    endtask

    initial begin
        rst      = 1'b1;
        keyByte  = 8'h00;
        keyWe    = 1'b0;
        fetchReq = 1'b0;
        fetch    = '0;
        modelRaw = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        tick();
        inRangeTest();
        bypassTest();
        heldStrobeTest();
        busyDropTest();
        reloadTest();
        resetMidTest();
        $display("checks done, %0d errors, %0d assertion failures",
                 errors, dut0.chk0.assertFails);
        if (errors == 0 && dut0.chk0.assertFails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((TEST_CYCLES + MARGIN) * PERIOD);
        $display("watchdog expired after %0d cycles, run did not finish", TEST_CYCLES + MARGIN);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== cps2FeistelRound.sv ====
/*
  CPS2 Feistel datapath
  Holds the left and right half-words. Load applies the whitening,
  each step applies one round with the indexed subkey and rotation.
  Bypass words skip both and come out as they went in.
*/
`timescale 1ns/1ps

module cps2FeistelRound (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic                      step,
    input  logic [1:0]                roundIdx,
    input  logic [15:0]               data,
    input  cps2DecryptPkg::roundKey_t roundKey,
    output logic [15:0]               plainData
);

    logic [7:0] left;       // high half
    logic [7:0] right;      // low half
    logic [7:0] mixed;      // round function output
    logic [2:0] rotAmt;     // 1..4 for rounds 0..3
    logic [7:0] whitenHi;
    logic [7:0] whitenLo;

    // rotate a byte left by n
    function automatic logic [7:0] rotl8(input logic [7:0] v, input logic [2:0] n);
        logic [15:0] dbl;
        dbl = {v, v} << n;
        return dbl[15:8];
    endfunction

    // no whitening for bypass words
    assign whitenHi = roundKey.encrypted ? roundKey.whiten[15:8] : 8'h00;
    assign whitenLo = roundKey.encrypted ? roundKey.whiten[7:0]  : 8'h00;

    assign rotAmt = {1'b0, roundIdx} + 3'd1;
    assign mixed  = rotl8(right ^ roundKey.subKey[roundIdx], rotAmt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left  <= 8'h00;
            right <= 8'h00;
        end else if (load) begin
            left  <= data[15:8] ^ whitenHi;
            right <= data[7:0]  ^ whitenLo;
        end else if (step && roundKey.encrypted) begin  // rounds gated for bypass
            left  <= right;
            right <= left ^ mixed;
        end
    end

    assign plainData = {left, right};

endmodule

// ==== cps2KeyLoad.sv ====
/*
  CPS2 key loader
  Takes the configuration blob one byte per rising edge of the
  write strobe into a shift register. A fixed bit scatter turns the
  blob into the 64-bit master key and the 16-bit address limit.
*/
`timescale 1ns/1ps

module cps2KeyLoad (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             keyByte,
    input  logic                   keyWe,
    output cps2DecryptPkg::keyCfg_t keyCfg
);

    `include "cps2Decrypt_macros.svh"

    localparam int BLOB_W    = 8 * `CPS2_BLOB_BYTES; // 160 bits of raw blob
    localparam int MAP_MUL   = 7;                    // byte stride, coprime with 20
    localparam int MAP_OFS   = 13;                   // byte offset of the scatter
    localparam int LIMIT_BIT = BLOB_W - 16;          // addrLimit sits in the top map bits

    logic              keyWePrev;   // strobe history for edge detect
    logic              keyTake;     // rising edge of keyWe
    logic [BLOB_W-1:0] raw;         // blob shift register

    // map bit j of the scrambled blob to its raw bit
    // byte j/8 comes from a strided byte, rotated by its own index
    function automatic int srcBit(input int j);
        int b;
        int k;
        b = j / 8;
        k = j % 8;
        return 8 * ((b * MAP_MUL + MAP_OFS) % `CPS2_BLOB_BYTES) + (k + b) % 8;
    endfunction

    assign keyTake = keyWe && !keyWePrev; // level held high counts once

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            keyWePrev <= 1'b0;           // low history after reset
        end else begin
            keyWePrev <= keyWe;
        end
    end

    // newest byte enters at the top, oldest ends up in raw[7:0]
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raw <= '0;                   // cleared key
        end else if (keyTake) begin
            raw <= {keyByte, raw[BLOB_W-1:8]};
        end
    end

    // master key is map bits 63..0
    for (genvar j = 0; j < 64; j++) begin : gKey
        assign keyCfg.masterKey[j] = raw[srcBit(j)];
    end

    // address limit is map bits 159..144
    for (genvar j = 0; j < 16; j++) begin : gLimit
        assign keyCfg.addrLimit[j] = raw[srcBit(LIMIT_BIT + j)];
    end

endmodule

// ==== cps2KeySchedule.sv ====
/*
  CPS2 key schedule
  Captures the fetch address and kind on acceptance, tests the
  address against the loaded limit and derives the whitening word
  and the address-tweaked round subkeys.
*/
`timescale 1ns/1ps

module cps2KeySchedule (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      capture,
    input  cps2DecryptPkg::fetch_t    fetch,
    input  cps2DecryptPkg::keyCfg_t   keyCfg,
    output cps2DecryptPkg::roundKey_t roundKey
);

    `include "cps2Decrypt_macros.svh"

    logic [`CPS2_ADDR_W-1:0] addrQ;   // captured word address
    logic                    opQ;     // captured fetch kind
    logic [`CPS2_ADDR_W-1:0] addrSel; // live on the capture cycle, held after
    logic                    opSel;
    logic [15:0]             addrHi;  // address bits 22..7 for the range test

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            opQ <= 1'b0;
        end else if (capture) begin
            opQ <= fetch.isOpcode;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            addrQ <= fetch.addr;
        end
    end

    // whitening is applied at load, before the fetch is registered
    assign addrSel = capture ? fetch.addr : addrQ;
    assign opSel   = capture ? fetch.isOpcode : opQ;
    assign addrHi  = addrSel[`CPS2_ADDR_W-1 -: 16];

    // data reads and words above the limit bypass the rounds
    assign roundKey.encrypted = opSel && (addrHi <= keyCfg.addrLimit);
    assign roundKey.whiten    = keyCfg.masterKey[63:48]; // key bytes 7 and 6

    // round i mixes key byte i with address byte 0 or 1
    for (genvar i = 0; i < `CPS2_ROUNDS; i++) begin : gSub
        assign roundKey.subKey[i] = keyCfg.masterKey[8*i +: 8] ^ addrSel[8*(i%2) +: 8];
    end

endmodule
